/* all.f */
+incdir+verilog
verilog/cpuCtrlPkg.sv
verilog/irqSync.sv
verilog/statusFlags.sv
verilog/cycleSequencer.sv
verilog/controlDecode.sv
verilog/controlTop.sv
sim/controlTop_properties.sv
sim/controlTop_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module controlTop_tb -Mdir obj_dir -f all.f \
	> sim.log 2>&1 &&
./obj_dir/VcontrolTop_tb >> sim.log 2>&1 ||
echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* sim/controlTop_properties.sv */
// Bound into controlTop; samples on the rising clock and is quiet while nReset is low
`timescale 1ns/1ps

module controlTop_properties (
	input logic Clock,
	input logic nReset,
	input cpuCtrlPkg::memoryCtrl_t memory,
	input cpuCtrlPkg::majorState_t state,
	input cpuCtrlPkg::subCycle_t subCycle,
	input cpuCtrlPkg::instrByte_t opcodeCond
);

	import cpuCtrlPkg::*;

	// Address latch and memory access never overlap
	aleOutsideAccess: assert property (@(posedge Clock) disable iff (!nReset)
		!(memory.Ale && !memory.nMe))
		else $error("Ale high while nMe low");

	writeOnlyInStore: assert property (@(posedge Clock) disable iff (!nReset)
		!memory.nWe |-> (state == Execute && subCycle == Cycle3 && opcodeCond.opcode == OpStw))
		else $error("nWe low outside STW execute Cycle3");

	// Entry always hands back to fetch
	entryReturnsToFetch: assert property (@(posedge Clock) disable iff (!nReset)
		(state == Interrupt && subCycle == Cycle3) |=> (state == Fetch && subCycle == Cycle0))
		else $error("interrupt Cycle3 not followed by fetch Cycle0");

endmodule

/* sim/controlTop_tb.sv */
// Memory is modelled only by nWait timing; instruction bytes and flags come from the table
`timescale 1ns/1ps
`include "cpuCtrl_consts.svh"

module controlTop_tb;

	import cpuCtrlPkg::*;

	typedef struct packed {
		instrByte_t instr;
		logic [`CPU_FLAG_WIDTH-1:0] flags;
		logic irqLow;
		logic [3:0] waitMax;
		logic [4:0] cycles;
		logic regWe;
		logic statusWe;
		pcSelect_t pcSel;
	} testRow_t;

	logic Clock;
	logic nReset;
	instrByte_t opcodeCond;
	logic [`CPU_FLAG_WIDTH-1:0] flags;
	logic nIrq;
	logic nWait;
	datapathCtrl_t datapath;
	memoryCtrl_t memory;
	logic [`CPU_FLAG_WIDTH-1:0] statusReg;
	logic carryFlag;

	testRow_t rows[$];
	int seed;
	int limitCycles;
	int currentTest;
	int errorCount;
	int rowErrors;
	int failedTests;
	logic irqEnabled;
	logic [`CPU_FLAG_WIDTH-1:0] expStatus;

	controlTop i_controlTop (.Clock(Clock), .nReset(nReset), .opcodeCond(opcodeCond),
		.flags(flags), .nIrq(nIrq), .nWait(nWait), .datapath(datapath), .memory(memory),
		.statusReg(statusReg), .carryFlag(carryFlag));

	bind controlTop controlTop_properties i_controlTop_properties (.Clock(Clock),
		.nReset(nReset), .memory(memory), .state(state), .subCycle(subCycle),
		.opcodeCond(opcodeCond));

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Fetch Cycle0 is the only Ale cycle without the ALU running
	function automatic logic atFetchStart();
		return memory.Ale && !datapath.AluEn;
	endfunction

	task automatic reportCheck(input logic ok, input string what);
		assert (ok) else begin
			$display("Mismatch at %0t: test %0d %s", $time, currentTest, what);
			errorCount++;
			rowErrors++;
		end
	endtask

	task automatic addRow(input opcode_t op, input logic [2:0] cond,
			input logic [3:0] rowFlags, input logic irqLow, input int waitMax,
			input int cycles, input logic regWe, input logic statusWe, input pcSelect_t pcSel);
		testRow_t row;
		row.instr = {op, cond};
		row.flags = rowFlags;
		row.irqLow = irqLow;
		row.waitMax = waitMax[3:0];
		row.cycles = cycles[4:0];
		row.regWe = regWe;
		row.statusWe = statusWe;
		row.pcSel = pcSel;
		rows.push_back(row);
	endtask

	task automatic buildTable();
		// op, cond, flags, irqLow, waitMax, cycles, RegWe, statusWe, PcSel
		addRow(OpAdd, 3'd0, 4'b0010, 1'b0, 0, 5, 1'b1, 1'b1, Pc1);
		addRow(OpAddI, 3'd0, 4'b0000, 1'b0, 2, 5, 1'b1, 1'b1, Pc1);
		addRow(OpLsl, 3'd0, 4'b1001, 1'b0, 0, 5, 1'b1, 1'b1, Pc1);
		addRow(OpCmpI, 3'd0, 4'b0110, 1'b0, 0, 5, 1'b0, 1'b1, Pc1);
		addRow(OpLui, 3'd0, 4'b1111, 1'b0, 0, 5, 1'b1, 1'b0, Pc1);
		addRow(OpLdw, 3'd0, 4'b0000, 1'b0, 3, 9, 1'b0, 1'b0, Pc1);
		addRow(OpStw, 3'd0, 4'b0000, 1'b0, 3, 9, 1'b0, 1'b0, Pc1);
		// Z set, N equals V
		addRow(OpCmp, 3'd0, 4'b0001, 1'b0, 0, 5, 1'b0, 1'b1, Pc1);
		addRow(OpBranch, Bne, 4'b1111, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpBranch, Be, 4'b1111, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Blt, 4'b1111, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpBranch, Bge, 4'b1111, 1'b0, 1, 5, 1'b0, 1'b0, PcAluOut);
		// Z clear, N differs from V
		addRow(OpCmp, 3'd0, 4'b1000, 1'b0, 0, 5, 1'b0, 1'b1, Pc1);
		addRow(OpBranch, Bne, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Be, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpBranch, Blt, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Bge, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		// N and V both set
		addRow(OpCmp, 3'd0, 4'b1100, 1'b0, 0, 5, 1'b0, 1'b1, Pc1);
		addRow(OpBranch, Blt, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpBranch, Bge, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Br, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Bwl, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Jmp, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcAluOut);
		addRow(OpBranch, Ret, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, PcSysbus);
		// Interrupt enable, entry, and the cleared enable afterwards
		addRow(OpInterrupt, IntOn, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpAdd, 3'd0, 4'b0101, 1'b1, 0, 5, 1'b1, 1'b1, Pc1);
		addRow(OpSub, 3'd0, 4'b0011, 1'b1, 0, 5, 1'b1, 1'b1, Pc1);
		addRow(OpInterrupt, IntOn, 4'b0000, 1'b1, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpInterrupt, IntOff, 4'b0000, 1'b1, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpXor, 3'd0, 4'b1010, 1'b1, 0, 5, 1'b1, 1'b1, Pc1);
		addRow(OpInterrupt, IntOn, 4'b0000, 1'b0, 0, 5, 1'b0, 1'b0, Pc1);
		addRow(OpLdw, 3'd0, 4'b0000, 1'b1, 2, 9, 1'b0, 1'b0, Pc1);
		addRow(OpOr, 3'd0, 4'b0100, 1'b1, 0, 5, 1'b1, 1'b1, Pc1);
	endtask

	task automatic runTest(input int index);
		testRow_t row;
		int c;
		int wf;
		int wm;
		int expLen;
		int entryWaitAt;
		int nWeCount;
		int nWeAt;
		logic mem;
		logic entry;
		logic done;
		logic regWeSeen;
		logic lrWeSeen;
		logic expLrWe;
		logic lastPcWe;
		pcSelect_t pcSelSeen;
		pcSelect_t lastPcSel;
		row = rows[index];
		currentTest = index;
		rowErrors = 0;
		mem = row.instr.opcode inside {OpLdw, OpStw};
		wf = $unsigned($random(seed)) % (row.waitMax + 1);
		wm = $unsigned($random(seed)) % (row.waitMax + 1);
		if (!mem)
			wm = 0;
		entry = irqEnabled && row.irqLow && row.instr.opcode != OpInterrupt;
		expLen = row.cycles + wf + wm + (entry ? 5 : 0);
		// Entry Cycle2 sees nWait low and must still take one cycle
		entryWaitAt = entry ? (mem ? 12 + wf + wm : 8 + wf) : 0;
		expLrWe = row.instr.opcode == OpBranch && row.instr.cond.branch == Bwl
			&& row.pcSel == PcAluOut;
		c = 0;
		done = 1'b0;
		nWeCount = 0;
		nWeAt = 0;
		regWeSeen = 1'b0;
		lrWeSeen = 1'b0;
		lastPcWe = 1'b0;
		pcSelSeen = Pc1;
		lastPcSel = Pc1;
		while (!done) begin
			@(posedge Clock);
			c++;
			if (c == 1) begin
				opcodeCond <= row.instr;
				flags <= row.flags;
				nIrq <= !row.irqLow;
			end
			// Hold fetch Cycle2, then the execute Cycle2 of a memory access
			nWait <= !((c >= 2 && c < 2 + wf) || (mem && c >= 7 + wf && c < 7 + wf + wm)
				|| c == entryWaitAt);
			@(negedge Clock);
			if (atFetchStart()) begin
				done = 1'b1;
			end else begin
				if (c == 4 + wf) begin
					regWeSeen = datapath.RegWe;
					lrWeSeen = datapath.LrWe;
					pcSelSeen = datapath.PcSel;
				end
				if (!memory.nWe) begin
					nWeCount++;
					nWeAt = c;
				end
				lastPcSel = datapath.PcSel;
				lastPcWe = datapath.PcWe;
			end
		end
		if (row.statusWe)
			expStatus = row.flags;
		reportCheck(c == expLen, $sformatf("length %0d, expected %0d", c, expLen));
		reportCheck(regWeSeen == row.regWe, $sformatf("RegWe %b, expected %b",
			regWeSeen, row.regWe));
		reportCheck(pcSelSeen == row.pcSel, $sformatf("PcSel %0d, expected %0d",
			pcSelSeen, row.pcSel));
		reportCheck(lrWeSeen == expLrWe, $sformatf("LrWe %b, expected %b", lrWeSeen, expLrWe));
		reportCheck(statusReg == expStatus, $sformatf("statusReg %b, expected %b",
			statusReg, expStatus));
		reportCheck(carryFlag == expStatus[`CPU_FLAG_C], "carryFlag differs from bit C");
		if (row.instr.opcode == OpStw)
			reportCheck(nWeCount == 1 && nWeAt == 8 + wf + wm,
				$sformatf("nWe low %0d times, last in cycle %0d", nWeCount, nWeAt));
		else
			reportCheck(nWeCount == 0, $sformatf("nWe low %0d times", nWeCount));
		reportCheck((lastPcSel == PcInt && lastPcWe) == entry,
			$sformatf("interrupt entry %b, expected %b", lastPcSel == PcInt, entry));
		// Model of the interrupt enable flag
		if (row.instr.opcode == OpInterrupt && row.instr.cond.intCode == IntOn)
			irqEnabled = 1'b1;
		if (row.instr.opcode == OpInterrupt && row.instr.cond.intCode == IntOff)
			irqEnabled = 1'b0;
		if (entry)
			irqEnabled = 1'b0;
		if (rowErrors != 0)
			failedTests++;
		$display("Test %0d opcode %0d: %0d cycles, waits %0d and %0d, %0d errors",
			index, row.instr.opcode, c, wf, wm, rowErrors);
	endtask

	initial begin
		int limit;
		nReset = 1'b0;
		opcodeCond = '0;
		flags = '0;
		nIrq = 1'b1;
		nWait = 1'b1;
		seed = 47230;
		limitCycles = 0;
		currentTest = -1;
		errorCount = 0;
		failedTests = 0;
		irqEnabled = 1'b0;
		expStatus = '0;
		limit = 0;
		buildTable();
		// Worst case per row is both waits at maximum plus an entry
		foreach (rows[i])
			limit += rows[i].cycles + 2 * rows[i].waitMax + 5;
		limitCycles = (limit + 5) * 2;
		repeat (5) @(posedge Clock);
		nReset <= 1'b1;
		@(negedge Clock);
		reportCheck(memory.Ale && memory.nMe && memory.nOe && memory.nWe,
			"strobes after reset");
		reportCheck(!(datapath.RegWe || datapath.PcWe || datapath.IrWe || datapath.LrWe
			|| datapath.AluWe), "write enable active after reset");
		reportCheck(statusReg == '0, "statusReg not cleared by reset");
		foreach (rows[i])
			runTest(i);
		$display("Tests %0d, failed tests %0d, failed checks %0d", rows.size(), failedTests,
			errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		wait (limitCycles != 0);
		repeat (limitCycles) @(posedge Clock);
		$display("Timeout: run did not finish within %0d cycles", limitCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog/controlDecode.sv */
// Outputs are combinational from state and the held instruction byte; nWait is not looked at here
`timescale 1ns/1ps

module controlDecode (
	input cpuCtrlPkg::majorState_t state,
	input cpuCtrlPkg::subCycle_t subCycle,
	input cpuCtrlPkg::instrByte_t instr,
	input logic branchTaken,
	output cpuCtrlPkg::datapathCtrl_t datapath,
	output cpuCtrlPkg::memoryCtrl_t memory,
	output logic statusWe,
	output logic intEnable,
	output logic intDisable
);

	import cpuCtrlPkg::*;

	always_comb begin
		// Zero selects are Pc1, Op1Rd1, Op2Imm, Rs1Ra, RwRd, WdAlu, LrSys and NoOverride
		datapath = '0;
		datapath.ImmSel = ImmLong;
		memory = '{Ale: 1'b0, nMe: 1'b1, nOe: 1'b1, nWe: 1'b1, MemEn: 1'b0, Enb: 1'b0};
		statusWe = 1'b0;
		intEnable = 1'b0;
		intDisable = 1'b0;
		case (state)
			Fetch: begin
				case (subCycle)
					Cycle0: begin
						memory.Ale = 1'b1;
						datapath.PcEn = 1'b1;
					end
					Cycle1: begin
						memory.nMe = 1'b0;
						memory.MemEn = 1'b1;
						datapath.PcEn = 1'b1;
					end
					Cycle2: begin
						memory.nMe = 1'b0;
						memory.nOe = 1'b0;
						memory.MemEn = 1'b1;
						memory.Enb = 1'b1;
						datapath.IrWe = 1'b1;
					end
					default:
						datapath.PcEn = 1'b1;
				endcase
			end
			Execute: begin
				case (subCycle)
					Cycle4: begin
						case (instr.opcode)
							OpLdw,
							OpStw: begin
								// Effective address first
								datapath.ImmSel = ImmShort;
								datapath.AluEn = 1'b1;
								datapath.AluWe = 1'b1;
							end
							OpLui,
							OpLli: begin
								datapath.Rs1Sel = Rs1Rd;
								datapath.AluEn = 1'b1;
								datapath.RegWe = 1'b1;
								datapath.PcWe = 1'b1;
							end
							OpBranch: begin
								case (instr.cond.branch)
									Ret: begin
										datapath.LrEn = 1'b1;
										datapath.PcSel = PcSysbus;
									end
									Jmp: begin
										datapath.ImmSel = ImmShort;
										datapath.AluEn = 1'b1;
										datapath.PcSel = PcAluOut;
									end
									default: begin
										// PC relative target
										datapath.Op1Sel = Op1Pc;
										datapath.AluEn = 1'b1;
										if (branchTaken)
											datapath.PcSel = PcAluOut;
										if (branchTaken && instr.cond.branch == Bwl) begin
											datapath.LrWe = 1'b1;
											datapath.LrSel = LrPc;
										end
									end
								endcase
								datapath.PcWe = 1'b1;
							end
							OpInterrupt: begin
								datapath.PcEn = 1'b1;
								datapath.PcWe = 1'b1;
								intEnable = instr.cond.intCode == IntOn;
								intDisable = instr.cond.intCode == IntOff;
							end
							default: begin
								// ALU, compare and shift group
								datapath.AluEn = 1'b1;
								datapath.PcEn = 1'b1;
								datapath.PcWe = 1'b1;
								datapath.RegWe = !(instr.opcode inside {OpCmp, OpCmpI});
								statusWe = 1'b1;
								if (instr.opcode inside {OpAdd, OpAdc, OpSub, OpSuc, OpCmp,
										OpAnd, OpOr, OpXor, OpNand, OpNor})
									datapath.Op2Sel = Op2Rd2;
								if (instr.opcode inside {OpAddI, OpSubI, OpCmpI, OpLsl, OpLsr, OpAsr})
									datapath.ImmSel = ImmShort;
								if (instr.opcode inside {OpAddIB, OpSubIB})
									datapath.Rs1Sel = Rs1Rd;
							end
						endcase
					end
					Cycle0: begin
						memory.Ale = 1'b1;
						datapath.ImmSel = ImmShort;
						datapath.AluEn = 1'b1;
					end
					Cycle1: begin
						// Pass Rd through the ALU for store data
						memory.nMe = 1'b0;
						memory.MemEn = instr.opcode == OpLdw;
						datapath.Op2Sel = Op2Zero;
						datapath.Rs1Sel = Rs1Rd;
						datapath.AluEn = 1'b1;
						datapath.AluWe = 1'b1;
					end
					Cycle2: begin
						memory.nMe = 1'b0;
						if (instr.opcode == OpLdw) begin
							memory.nOe = 1'b0;
							memory.MemEn = 1'b1;
							memory.Enb = 1'b1;
							datapath.WdSel = WdSys;
							// Rewrites harmlessly while nWait holds Cycle2
							datapath.RegWe = 1'b1;
						end else begin
							datapath.Op2Sel = Op2Zero;
							datapath.AluEn = 1'b1;
						end
					end
					default: begin
						datapath.PcWe = 1'b1;
						if (instr.opcode == OpStw) begin
							memory.nWe = 1'b0;
							datapath.Op2Sel = Op2Zero;
							datapath.AluEn = 1'b1;
						end else begin
							datapath.PcEn = 1'b1;
						end
					end
				endcase
			end
			default: begin
				// Interrupt entry pushes the PC below SP
				datapath.Rs1Sel = Rs1Sp;
				datapath.Op2Sel = Op2Zero;
				case (subCycle)
					Cycle4: begin
						intDisable = 1'b1;
						datapath.AluOR = SubOverride;
						datapath.AluEn = 1'b1;
						datapath.AluWe = 1'b1;
						datapath.RwSel = RwSp;
						datapath.RegWe = 1'b1;
					end
					Cycle0: begin
						memory.Ale = 1'b1;
						datapath.AluOR = SubOverride;
						datapath.AluEn = 1'b1;
					end
					Cycle1: begin
						memory.nMe = 1'b0;
						datapath.AluEn = 1'b1;
					end
					Cycle2: begin
						memory.nMe = 1'b0;
						datapath.PcEn = 1'b1;
					end
					default: begin
						datapath.PcEn = 1'b1;
						datapath.PcSel = PcInt;
						datapath.PcWe = 1'b1;
					end
				endcase
			end
		endcase
	end

endmodule

/* verilog/controlTop.sv */
// opcodeCond must come from the instruction register and stay stable through execute
`timescale 1ns/1ps
`include "cpuCtrl_consts.svh"

module controlTop (
	input logic Clock,
	input logic nReset,
	input cpuCtrlPkg::instrByte_t opcodeCond,
	input logic [`CPU_FLAG_WIDTH-1:0] flags,
	input logic nIrq,
	input logic nWait,
	output cpuCtrlPkg::datapathCtrl_t datapath,
	output cpuCtrlPkg::memoryCtrl_t memory,
	output logic [`CPU_FLAG_WIDTH-1:0] statusReg,
	output logic carryFlag
);

	cpuCtrlPkg::majorState_t state;
	cpuCtrlPkg::subCycle_t subCycle;
	logic intReq;
	logic intEnable;
	logic intDisable;
	logic statusWe;
	logic branchTaken;

	irqSync i_irqSync (.Clock, .nReset, .nIrq, .intEnable, .intDisable, .intReq);

	statusFlags i_statusFlags (.Clock, .nReset, .flags, .statusWe, .cond(opcodeCond.cond),
		.statusReg, .branchTaken);

	cycleSequencer i_cycleSequencer (.Clock, .nReset, .opcode(opcodeCond.opcode), .intReq,
		.nWait, .state, .subCycle);

	controlDecode i_controlDecode (.state, .subCycle, .instr(opcodeCond), .branchTaken,
		.datapath, .memory, .statusWe, .intEnable, .intDisable);

	// Carry into the ALU for ADC and SUC
	assign carryFlag = statusReg[`CPU_FLAG_C];

endmodule

/* verilog/cpuCtrlPkg.sv */
// Encodings here must match the assembler; only the opcodes kept in this core are listed
`include "cpuCtrl_consts.svh"

package cpuCtrlPkg;

	typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
		OpAdd = 5'd0, OpAddI, OpAddIB, OpAdc, OpAdcI,
		OpSub, OpSubI, OpSubIB, OpSuc, OpSucI,
		OpCmp, OpCmpI, OpAnd, OpOr, OpXor,
		OpNot, OpNand, OpNor, OpLsl, OpLsr,
		OpAsr, OpNeg, OpLui, OpLli, OpLdw,
		OpStw, OpBranch, OpInterrupt
	} opcode_t;

	typedef enum logic [`CPU_COND_WIDTH-1:0] {
		Br, Bne, Be, Blt, Bge, Bwl, Ret, Jmp
	} branchCond_t;

	// Only enable and disable remain of the interrupt group
	typedef enum logic [`CPU_COND_WIDTH-1:0] {
		IntOn = 3'd1,
		IntOff = 3'd2
	} intCode_t;

	// Same three bits, read per opcode
	typedef union packed {
		branchCond_t branch;
		intCode_t intCode;
	} condField_u;

	typedef struct packed {
		opcode_t opcode;
		condField_u cond;
	} instrByte_t;

	typedef enum logic [$clog2(`CPU_MAJOR_STATE_COUNT)-1:0] {
		Fetch, Execute, Interrupt
	} majorState_t;

	typedef enum logic [$clog2(`CPU_SUBCYCLE_COUNT)-1:0] {
		Cycle0, Cycle1, Cycle2, Cycle3, Cycle4
	} subCycle_t;

	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSelect_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Select_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Select_t;
	typedef enum logic {ImmShort, ImmLong} immSelect_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1Select_t;
	typedef enum logic {RwRd, RwSp} rwSelect_t;
	typedef enum logic {WdAlu, WdSys} wdSelect_t;
	typedef enum logic {LrSys, LrPc} lrSelect_t;
	typedef enum logic {NoOverride, SubOverride} aluOverride_t;

	typedef struct packed {
		pcSelect_t PcSel;
		op1Select_t Op1Sel;
		op2Select_t Op2Sel;
		immSelect_t ImmSel;
		rs1Select_t Rs1Sel;
		rwSelect_t RwSel;
		wdSelect_t WdSel;
		lrSelect_t LrSel;
		aluOverride_t AluOR;
		logic AluEn;
		logic AluWe;
		logic LrEn;
		logic LrWe;
		logic PcEn;
		logic PcWe;
		logic IrWe;
		logic RegWe;
	} datapathCtrl_t;

	// Memory strobes, the n-prefixed ones are active low
	typedef struct packed {
		logic Ale;
		logic nMe;
		logic nOe;
		logic nWe;
		logic MemEn;
		logic Enb;
	} memoryCtrl_t;

endpackage

/* verilog/cpuCtrl_consts.svh */
// Widths and bit positions assume the 16-bit core with an 8-bit opcode/condition byte
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// Instruction byte fields
`define CPU_OPCODE_WIDTH 5
`define CPU_COND_WIDTH 3

// Status register
`define CPU_FLAG_WIDTH 4

// Flag bit positions within the status register
`define CPU_FLAG_Z 0
`define CPU_FLAG_C 1
`define CPU_FLAG_V 2
`define CPU_FLAG_N 3

// Fetch, execute and interrupt
`define CPU_MAJOR_STATE_COUNT 3

// Cycle0 to Cycle4
`define CPU_SUBCYCLE_COUNT 5

// Interrupt request synchroniser depth, must be at least 2
`define CPU_SYNC_STAGES 2

`endif

/* verilog/cycleSequencer.sv */
// opcode must be held by the instruction register from Execute Cycle4 to the end of the instruction
`timescale 1ns/1ps

module cycleSequencer (
	input logic Clock,
	input logic nReset,
	input cpuCtrlPkg::opcode_t opcode,
	input logic intReq,
	input logic nWait,
	output cpuCtrlPkg::majorState_t state,
	output cpuCtrlPkg::subCycle_t subCycle
);

	import cpuCtrlPkg::*;

	majorState_t nextState;
	subCycle_t nextSub;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			state <= Fetch;
			subCycle <= Cycle0;
		end else begin
			state <= nextState;
			subCycle <= nextSub;
		end
	end

	always_comb begin
		nextState = state;
		nextSub = subCycle;
		case (subCycle)
			Cycle0:
				nextSub = Cycle1;
			Cycle1:
				nextSub = Cycle2;
			Cycle2:
				// Memory stretches here, interrupt entry does not
				if (nWait || state == Interrupt)
					nextSub = Cycle3;
			Cycle3: begin
				if (state == Fetch) begin
					nextState = Execute;
					nextSub = Cycle4;
				end else if (state == Execute && intReq) begin
					nextState = Interrupt;
					nextSub = Cycle4;
				end else begin
					nextState = Fetch;
					nextSub = Cycle0;
				end
			end
			Cycle4: begin
				if (state != Execute || opcode inside {OpLdw, OpStw}) begin
					nextSub = Cycle0;
				end else if (intReq && opcode != OpInterrupt) begin
					nextState = Interrupt;
				end else begin
					// Single-cycle op finishes here
					nextState = Fetch;
					nextSub = Cycle0;
				end
			end
			default: begin
				nextState = Fetch;
				nextSub = Cycle0;
			end
		endcase
	end

endmodule

/* verilog/irqSync.sv */
// nIrq may be fully asynchronous; a request pulse shorter than one clock period can be missed
`timescale 1ns/1ps
`include "cpuCtrl_consts.svh"

module irqSync (
	input logic Clock,
	input logic nReset,
	input logic nIrq,
	input logic intEnable,
	input logic intDisable,
	output logic intReq
);

	logic [`CPU_SYNC_STAGES-1:0] syncReg;
	logic enableFlag;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			syncReg <= '0;
			enableFlag <= 1'b0;
		end else begin
			// Pin is active low
			syncReg <= {syncReg[`CPU_SYNC_STAGES-2:0], ~nIrq};
			// Disable wins if both arrive together
			if (intDisable)
				enableFlag <= 1'b0;
			else if (intEnable)
				enableFlag <= 1'b1;
		end
	end

	assign intReq = syncReg[`CPU_SYNC_STAGES-1] & enableFlag;

endmodule

/* verilog/statusFlags.sv */
// flags must be valid in the cycle where statusWe is high; branchTaken is meaningless for RET and JMP
`timescale 1ns/1ps
`include "cpuCtrl_consts.svh"

module statusFlags (
	input logic Clock,
	input logic nReset,
	input logic [`CPU_FLAG_WIDTH-1:0] flags,
	input logic statusWe,
	input cpuCtrlPkg::condField_u cond,
	output logic [`CPU_FLAG_WIDTH-1:0] statusReg,
	output logic branchTaken
);

	import cpuCtrlPkg::*;

	logic zeroFlag;
	logic signMatch;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			statusReg <= '0;
		else if (statusWe)
			statusReg <= flags;
	end

	assign zeroFlag = statusReg[`CPU_FLAG_Z];

	// Signed compare result, N xor V gives less-than
	assign signMatch = statusReg[`CPU_FLAG_N] == statusReg[`CPU_FLAG_V];

	always_comb begin
		case (cond.branch)
			Br,
			Bwl:
				branchTaken = 1'b1;
			Bne:
				branchTaken = !zeroFlag;
			Be:
				branchTaken = zeroFlag;
			Blt:
				branchTaken = !signMatch;
			Bge:
				branchTaken = signMatch;
			// Unconditional transfers are decoded elsewhere
			default:
				branchTaken = 1'b0;
		endcase
	end

endmodule
